/* filelist.f */
cpuIsaPkg.sv
cpuPipePkg.sv
regFile.sv
hazardUnit.sv
fetchUnit.sv
decodeUnit.sv
executeUnit.sv
memWbUnit.sv
cpuTop.sv
tbClockGen.sv
tbCpu.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run tbCpu, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tbCpu \
  -f filelist.f -o tbCpuSim \
  || { echo "build failed"; exit 1; }
out="$(./obj_dir/tbCpuSim 2>&1)"
echo "$out"
echo "$out" | grep -qx "Result: PASSED" \
  && echo "simulation run ok" \
  || { echo "simulation run not ok"; exit 1; }

/* tbCpu.sv */
// programs must fit the 64-word instruction image; data memory is 256 words on the low 8 address bits
`timescale 1ns/1ns
`default_nettype none

module tbCpu;

  localparam int imemWords = 64;
  localparam int dmemWords = 256;
  localparam int resetTimeout = 10;
  localparam int haltTimeout = 200;
  localparam int modelStepLimit = 200;
  localparam int quietCycles = 20;

  logic            clk;
  logic            rstN;
  logic            resetReq;
  cpuIsaPkg::wordT imemAddr;
  cpuIsaPkg::wordT imemData;
  cpuIsaPkg::wordT dmemAddr;
  cpuIsaPkg::wordT dmemWrData;
  logic            dmemWe;
  cpuIsaPkg::wordT dmemRdData;
  logic            halted;

  cpuIsaPkg::wordT imem [imemWords];
  cpuIsaPkg::wordT dmem [dmemWords];
  cpuIsaPkg::wordT refMem [dmemWords];
  cpuIsaPkg::wordT refRegs [cpuIsaPkg::numRegs];
  cpuIsaPkg::wordT prog [$];
  // expected stores as {address, data}
  logic [31:0]     expStores [$];
  int              seed;
  int              storesSeen = 0;
  logic            rstWasLow;

  tbClockGen i_clkGen (.clk(clk), .rstN(rstN), .resetReq(resetReq));

  cpuTop i_dut (
    .clk(clk), .rstN(rstN),
    .imemAddr(imemAddr), .imemData(imemData),
    .dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWe(dmemWe), .dmemRdData(dmemRdData),
    .halted(halted)
  );

  // both memories answer combinationally
  assign imemData = imem[imemAddr[6:1]];
  assign dmemRdData = dmem[dmemAddr[7:0]];

  task automatic reportMismatch(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    $display("Result: FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic abortRun(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "run aborted");
  endtask

  // ADDI and LD write rt while ST stores rt at rs plus imm5
  function automatic cpuIsaPkg::wordT immInstr(cpuIsaPkg::opcodeT op, int rs, int rt, int imm);
    return {op, rs[2:0], rt[2:0], imm[4:0]};
  endfunction

  function automatic cpuIsaPkg::wordT regInstr(cpuIsaPkg::aluFuncT fn, int rd, int rs, int rt);
    return {cpuIsaPkg::RTYPE, rs[2:0], rt[2:0], rd[2:0], fn};
  endfunction

  // offset counts instructions from pc+2
  function automatic cpuIsaPkg::wordT branchInstr(cpuIsaPkg::opcodeT op, int rs, int off);
    return {op, rs[2:0], off[7:0]};
  endfunction

  // store monitor samples on the rising edge before registers update
  always @(posedge clk) begin
    logic [31:0] expPair;
    if (!rstN || rstWasLow) begin
      assert (!dmemWe && !halted)
        else reportMismatch($sformatf("around reset dmemWe=%b halted=%b, expected both 0",
                                      dmemWe, halted));
    end
    rstWasLow <= !rstN;
    if (rstN && dmemWe) begin
      storesSeen = storesSeen + 1;
      assert (expStores.size() > 0)
        else reportMismatch($sformatf("store %h to %h but the model expects no more stores",
                                      dmemWrData, dmemAddr));
      if (expStores.size() > 0) begin
        expPair = expStores.pop_front();
        assert ({dmemAddr, dmemWrData} == expPair)
          else reportMismatch($sformatf("store expected addr %h data %h, got addr %h data %h",
                                        expPair[31:16], expPair[15:0], dmemAddr, dmemWrData));
      end
      dmem[dmemAddr[7:0]] <= dmemWrData;
    end
  end

  // sequential ISA model that fills expStores
  task automatic runModel(input string name);
    cpuIsaPkg::wordT pc;
    cpuIsaPkg::wordT instr;
    cpuIsaPkg::wordT a;
    cpuIsaPkg::wordT b;
    cpuIsaPkg::wordT res;
    cpuIsaPkg::wordT imm5;
    cpuIsaPkg::wordT imm8;
    cpuIsaPkg::wordT addr;
    logic [4:0]      op;
    logic [2:0]      rs;
    logic [2:0]      rt;
    logic [2:0]      rd;
    logic            done;
    int              steps;
    for (int i = 0; i < cpuIsaPkg::numRegs; i++) begin
      refRegs[i] = '0;
    end
    pc = '0;
    done = 1'b0;
    steps = 0;
    while (!done) begin
      instr = imem[pc[6:1]];
      op = instr[15:11];
      rs = instr[10:8];
      rt = instr[7:5];
      rd = instr[4:2];
      imm5 = {{11{instr[4]}}, instr[4:0]};
      imm8 = {{8{instr[7]}}, instr[7:0]};
      a = refRegs[rs];
      b = refRegs[rt];
      addr = a + imm5;
      pc = pc + 16'd2;
      case (op)
        cpuIsaPkg::HALT: done = 1'b1;
        cpuIsaPkg::ADDI: refRegs[rt] = addr;
        cpuIsaPkg::LD: refRegs[rt] = refMem[addr[7:0]];
        cpuIsaPkg::ST: begin
          expStores.push_back({addr, b});
          refMem[addr[7:0]] = b;
        end
        cpuIsaPkg::BEQZ: if (a == '0) pc = pc + imm8 * 16'd2;
        cpuIsaPkg::BNEZ: if (a != '0) pc = pc + imm8 * 16'd2;
        cpuIsaPkg::RTYPE: begin
          case (instr[1:0])
            2'd0: res = a + b;
            2'd1: res = a - b;
            2'd2: res = a ^ b;
            default: res = a & b;
          endcase
          refRegs[rd] = res;
        end
        default: ;
      endcase
      steps++;
      if (!done && steps > modelStepLimit) begin
        abortRun($sformatf("model of %s did not reach HALT in %0d steps", name, modelStepLimit));
      end
    end
  endtask

  task automatic runProgram(input string name);
    logic [31:0] rnd;
    int          expCount;
    int          baseCount;
    int          cycles;
    for (int i = 0; i < dmemWords; i++) begin
      rnd = $random(seed);
      dmem[i] <= rnd[15:0];
      refMem[i] = rnd[15:0];
    end
    // unused words are NOPs that carry their own address
    for (int i = 0; i < imemWords; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : {cpuIsaPkg::NOP, 11'(i)};
    end
    expStores.delete();
    runModel(name);
    expCount = expStores.size();
    baseCount = storesSeen;

    @(negedge clk);
    resetReq <= 1'b1;
    @(negedge clk);
    resetReq <= 1'b0;
    cycles = 0;
    while (rstN) begin
      @(posedge clk);
      cycles++;
      if (cycles > resetTimeout) abortRun($sformatf("%s: reset never asserted", name));
    end
    cycles = 0;
    while (!rstN) begin
      @(posedge clk);
      cycles++;
      if (cycles > resetTimeout) abortRun($sformatf("%s: reset never released", name));
    end

    cycles = 0;
    while (!halted) begin
      @(negedge clk);
      cycles++;
      if (cycles > haltTimeout) begin
        abortRun($sformatf("%s: halted did not rise within %0d cycles", name, haltTimeout));
      end
    end
    assert (storesSeen - baseCount == expCount)
      else reportMismatch($sformatf("%s: expected %0d stores, saw %0d",
                                    name, expCount, storesSeen - baseCount));
    // nothing may leave the core once halted
    for (int i = 0; i < quietCycles; i++) begin
      @(negedge clk);
      assert (!dmemWe && halted)
        else reportMismatch($sformatf("%s after halt: expected dmemWe=0 halted=1, got %b %b",
                                      name, dmemWe, halted));
    end
    $display("%s: %0d stores checked", name, expCount);
  endtask

  initial begin
    resetReq <= 1'b0;
    seed = 32'h99fa;

    // dependent ALU chain with operands from EX/MEM, MEM/WB and the bypass
    prog.delete();
    prog.push_back(immInstr(cpuIsaPkg::ADDI, 0, 1, 5));
    prog.push_back(immInstr(cpuIsaPkg::ADDI, 1, 2, -3));
    prog.push_back(regInstr(cpuIsaPkg::ADD, 3, 1, 2));
    prog.push_back(regInstr(cpuIsaPkg::SUB, 4, 3, 1));
    prog.push_back(regInstr(cpuIsaPkg::XOR, 5, 4, 3));
    prog.push_back(regInstr(cpuIsaPkg::AND, 6, 5, 3));
    prog.push_back(immInstr(cpuIsaPkg::ST, 1, 6, 1));
    prog.push_back(regInstr(cpuIsaPkg::SUB, 7, 2, 6));
    prog.push_back(immInstr(cpuIsaPkg::ST, 0, 7, 2));
    prog.push_back({cpuIsaPkg::HALT, 11'd0});
    runProgram("alu chain");

    // load-use on an ALU operand and on store data
    prog.delete();
    prog.push_back(immInstr(cpuIsaPkg::ADDI, 0, 1, 10));
    prog.push_back(immInstr(cpuIsaPkg::LD, 1, 2, 0));
    prog.push_back(regInstr(cpuIsaPkg::ADD, 3, 2, 1));
    prog.push_back(immInstr(cpuIsaPkg::ST, 0, 3, 2));
    prog.push_back(immInstr(cpuIsaPkg::LD, 1, 4, 1));
    prog.push_back(immInstr(cpuIsaPkg::ST, 1, 4, 3));
    prog.push_back(immInstr(cpuIsaPkg::LD, 0, 5, 2));
    prog.push_back(regInstr(cpuIsaPkg::SUB, 6, 5, 4));
    prog.push_back(immInstr(cpuIsaPkg::ST, 0, 6, 5));
    prog.push_back({cpuIsaPkg::HALT, 11'd0});
    runProgram("load use");

    // taken branches put stores in both shadow slots
    prog.delete();
    prog.push_back(immInstr(cpuIsaPkg::ADDI, 0, 2, 3));
    prog.push_back(branchInstr(cpuIsaPkg::BEQZ, 1, 2));
    prog.push_back(immInstr(cpuIsaPkg::ST, 0, 2, 7));
    prog.push_back(immInstr(cpuIsaPkg::ST, 0, 2, 8));
    prog.push_back(branchInstr(cpuIsaPkg::BNEZ, 1, 2));
    prog.push_back(immInstr(cpuIsaPkg::ST, 0, 2, 9));
    prog.push_back(branchInstr(cpuIsaPkg::BEQZ, 2, 2));
    prog.push_back(immInstr(cpuIsaPkg::ST, 0, 2, 10));
    // countdown loop on a backward BNEZ
    prog.push_back(immInstr(cpuIsaPkg::ADDI, 2, 2, -1));
    prog.push_back(immInstr(cpuIsaPkg::ST, 2, 2, 12));
    prog.push_back(branchInstr(cpuIsaPkg::BNEZ, 2, -3));
    prog.push_back(immInstr(cpuIsaPkg::ST, 0, 2, 13));
    prog.push_back(immInstr(cpuIsaPkg::ST, 0, 2, 14));
    prog.push_back({cpuIsaPkg::HALT, 11'd0});
    runProgram("branches");

    // stores behind HALT must never reach memory
    prog.delete();
    prog.push_back(immInstr(cpuIsaPkg::ADDI, 0, 1, 9));
    prog.push_back(immInstr(cpuIsaPkg::ST, 0, 1, 15));
    prog.push_back({cpuIsaPkg::HALT, 11'd0});
    prog.push_back(immInstr(cpuIsaPkg::ST, 0, 1, -15));
    prog.push_back(immInstr(cpuIsaPkg::ST, 0, 1, -14));
    prog.push_back(immInstr(cpuIsaPkg::ST, 1, 1, 1));
    runProgram("halt");

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tbClockGen.sv */
// 100 ns clock; rstN starts low and goes low again for 3 cycles after resetReq is seen on a falling edge
`timescale 1ns/1ns
`default_nettype none

module tbClockGen (
  output logic clk,
  output logic rstN,
  input  logic resetReq
);

  localparam int rstCycles = 3;

  int lowCycles;

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset is asserted and released on falling edges only
  initial begin
    rstN = 1'b0;
    lowCycles = 0;
    forever begin
      @(negedge clk);
      if (resetReq) begin
        rstN = 1'b0;
        lowCycles = 0;
      end else if (!rstN) begin
        lowCycles++;
        if (lowCycles == rstCycles) begin
          rstN = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* cpuTop.sv */
// both memories must return read data in the same cycle; once halted only reset restarts the core
`timescale 1ns/1ns
`default_nettype none

module cpuTop (
  input  logic            clk,
  input  logic            rstN,
  output cpuIsaPkg::wordT imemAddr,
  input  cpuIsaPkg::wordT imemData,
  output cpuIsaPkg::wordT dmemAddr,
  output cpuIsaPkg::wordT dmemWrData,
  output logic            dmemWe,
  input  cpuIsaPkg::wordT dmemRdData,
  output logic            halted
);

  // pipeline registers
  cpuPipePkg::ifIdT  ifId;
  cpuPipePkg::idExT  idEx;
  cpuPipePkg::exMemT exMem;
  cpuPipePkg::memWbT memWb;

  // hazard control
  logic               stall;
  cpuPipePkg::fwdSelT fwdA;
  cpuPipePkg::fwdSelT fwdB;
  logic               decUsesA;
  logic               decUsesB;

  // branch redirect out of execute
  logic            branchTaken;
  cpuIsaPkg::wordT branchTarget;

  // register file ports
  cpuIsaPkg::regIdxT rdAddrA;
  cpuIsaPkg::regIdxT rdAddrB;
  cpuIsaPkg::wordT   rdDataA;
  cpuIsaPkg::wordT   rdDataB;
  logic              wbEn;
  cpuIsaPkg::regIdxT wbIdx;
  cpuIsaPkg::wordT   wbData;

  fetchUnit i_fetch (
    .clk(clk), .rstN(rstN),
    .stall(stall), .branchTaken(branchTaken), .branchTarget(branchTarget),
    .exMem(exMem),
    .imemAddr(imemAddr), .imemData(imemData),
    .ifId(ifId)
  );

  decodeUnit i_decode (
    .clk(clk), .rstN(rstN),
    .ifId(ifId), .stall(stall), .branchTaken(branchTaken), .exMem(exMem),
    .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
    .decUsesA(decUsesA), .decUsesB(decUsesB),
    .idEx(idEx)
  );

  regFile i_regFile (
    .clk(clk), .rstN(rstN),
    .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rdDataA(rdDataA), .rdDataB(rdDataB),
    .wbEn(wbEn), .wbIdx(wbIdx), .wbData(wbData)
  );

  hazardUnit i_hazard (
    .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .decUsesA(decUsesA), .decUsesB(decUsesB),
    .idEx(idEx), .exMem(exMem), .memWb(memWb),
    .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
  );

  executeUnit i_execute (
    .clk(clk), .rstN(rstN),
    .idEx(idEx), .fwdA(fwdA), .fwdB(fwdB),
    .exMem(exMem), .wbData(wbData),
    .branchTaken(branchTaken), .branchTarget(branchTarget)
  );

  memWbUnit i_memWb (
    .clk(clk), .rstN(rstN),
    .exMem(exMem),
    .dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWe(dmemWe), .dmemRdData(dmemRdData),
    .memWb(memWb),
    .wbEn(wbEn), .wbIdx(wbIdx), .wbData(wbData),
    .halted(halted)
  );

endmodule

`default_nettype wire

/* memWbUnit.sv */
// data memory is driven straight from EX/MEM and must answer within the cycle
`timescale 1ns/1ns
`default_nettype none

module memWbUnit (
  input  logic              clk,
  input  logic              rstN,
  input  cpuPipePkg::exMemT exMem,
  output cpuIsaPkg::wordT   dmemAddr,
  output cpuIsaPkg::wordT   dmemWrData,
  output logic              dmemWe,
  input  cpuIsaPkg::wordT   dmemRdData,
  output cpuPipePkg::memWbT memWb,
  output logic              wbEn,
  output cpuIsaPkg::regIdxT wbIdx,
  output cpuIsaPkg::wordT   wbData,
  output logic              halted
);

  logic haltSeen;

  assign dmemAddr = exMem.aluRes;
  assign dmemWrData = exMem.stData;
  assign dmemWe = exMem.isStore;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memWb <= '0;
      haltSeen <= 1'b0;
    end else begin
      memWb <= '{
        aluRes: exMem.aluRes,
        ldData: dmemRdData,
        dest: exMem.dest,
        wrEn: exMem.wrEn,
        isLoad: exMem.isLoad,
        halt: exMem.halt
      };
      // sticky until reset
      haltSeen <= haltSeen | memWb.halt;
    end
  end

  assign wbEn = memWb.wrEn;
  assign wbIdx = memWb.dest;
  assign wbData = memWb.isLoad ? memWb.ldData : memWb.aluRes;

  // high from the cycle HALT sits in MEM/WB
  assign halted = haltSeen | memWb.halt;

endmodule

`default_nettype wire

/* executeUnit.sv */
// branch offset is imm8 words from pc+2; a load in EX/MEM never needs forwarding because decode stalls
`timescale 1ns/1ns
`default_nettype none

module executeUnit (
  input  logic               clk,
  input  logic               rstN,
  input  cpuPipePkg::idExT   idEx,
  input  cpuPipePkg::fwdSelT fwdA,
  input  cpuPipePkg::fwdSelT fwdB,
  output cpuPipePkg::exMemT  exMem,
  input  cpuIsaPkg::wordT    wbData,
  output logic               branchTaken,
  output cpuIsaPkg::wordT    branchTarget
);

  cpuIsaPkg::wordT    opA;
  cpuIsaPkg::wordT    opB;
  cpuIsaPkg::wordT    aluIn2;
  cpuIsaPkg::wordT    aluRes;
  cpuIsaPkg::aluFuncT func;

  function automatic cpuIsaPkg::wordT fwdMux(
    input cpuPipePkg::fwdSelT sel,
    input cpuIsaPkg::wordT    regVal,
    input cpuIsaPkg::wordT    exMemVal,
    input cpuIsaPkg::wordT    memWbVal
  );
    case (sel)
      cpuPipePkg::FROM_EXMEM: return exMemVal;
      cpuPipePkg::FROM_MEMWB: return memWbVal;
      default: return regVal;
    endcase
  endfunction

  assign opA = fwdMux(fwdA, idEx.valA, exMem.aluRes, wbData);
  assign opB = fwdMux(fwdB, idEx.valB, exMem.aluRes, wbData);

  // ADDI, LD and ST add the immediate
  assign aluIn2 = (idEx.op == cpuIsaPkg::RTYPE) ? opB : idEx.imm;
  assign func = (idEx.op == cpuIsaPkg::RTYPE) ? idEx.func : cpuIsaPkg::ADD;

  always_comb begin
    case (func)
      cpuIsaPkg::ADD: aluRes = opA + aluIn2;
      cpuIsaPkg::SUB: aluRes = opA - aluIn2;
      cpuIsaPkg::XOR: aluRes = opA ^ aluIn2;
      default:        aluRes = opA & aluIn2;
    endcase
  end

  // no redirect once a halt is ahead
  assign branchTaken = !exMem.halt &&
                       ((idEx.brZero && opA == '0) || (idEx.brNonZero && opA != '0));
  assign branchTarget = idEx.pcInc + {idEx.imm[cpuIsaPkg::wordW-2:0], 1'b0};

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exMem <= '0;
    end else if (exMem.halt) begin
      // whatever follows HALT is squashed here
      exMem <= '0;
    end else begin
      exMem <= '{
        aluRes: aluRes,
        stData: opB,
        dest: idEx.dest,
        wrEn: idEx.wrEn,
        isLoad: idEx.isLoad,
        isStore: idEx.isStore,
        halt: idEx.halt
      };
    end
  end

endmodule

`default_nettype wire

/* decodeUnit.sv */
// sources and destination come from fixed fields; unknown opcodes become bubbles
`timescale 1ns/1ns
`default_nettype none

module decodeUnit (
  input  logic              clk,
  input  logic              rstN,
  input  cpuPipePkg::ifIdT  ifId,
  input  logic              stall,
  input  logic              branchTaken,
  input  cpuPipePkg::exMemT exMem,
  output cpuIsaPkg::regIdxT rdAddrA,
  output cpuIsaPkg::regIdxT rdAddrB,
  input  cpuIsaPkg::wordT   rdDataA,
  input  cpuIsaPkg::wordT   rdDataB,
  output logic              decUsesA,
  output logic              decUsesB,
  output cpuPipePkg::idExT  idEx
);

  cpuIsaPkg::opcodeT            opcode;
  logic [cpuIsaPkg::imm5W-1:0]  imm5;
  logic [cpuIsaPkg::imm8W-1:0]  imm8;
  cpuIsaPkg::wordT              imm5Ext;
  cpuIsaPkg::wordT              imm8Ext;
  cpuPipePkg::idExT             dec;

  assign opcode = cpuIsaPkg::opcodeT'(ifId.instr[cpuIsaPkg::opLsb +: cpuIsaPkg::opcodeW]);
  assign imm5 = ifId.instr[cpuIsaPkg::imm5Lsb +: cpuIsaPkg::imm5W];
  assign imm8 = ifId.instr[cpuIsaPkg::imm8Lsb +: cpuIsaPkg::imm8W];

  assign imm5Ext = {{(cpuIsaPkg::wordW - cpuIsaPkg::imm5W){imm5[cpuIsaPkg::imm5W-1]}}, imm5};
  assign imm8Ext = {{(cpuIsaPkg::wordW - cpuIsaPkg::imm8W){imm8[cpuIsaPkg::imm8W-1]}}, imm8};

  // register file is addressed straight from the rs and rt fields
  assign rdAddrA = ifId.instr[cpuIsaPkg::rsLsb +: cpuIsaPkg::regIdxW];
  assign rdAddrB = ifId.instr[cpuIsaPkg::rtLsb +: cpuIsaPkg::regIdxW];

  always_comb begin
    dec = cpuPipePkg::idExBubble;
    decUsesA = 1'b0;
    decUsesB = 1'b0;
    if (ifId.valid) begin
      dec.op = opcode;
      dec.func = cpuIsaPkg::aluFuncT'(ifId.instr[cpuIsaPkg::funcLsb +: cpuIsaPkg::funcW]);
      dec.rs = rdAddrA;
      dec.rt = rdAddrB;
      dec.dest = rdAddrB;
      dec.valA = rdDataA;
      dec.valB = rdDataB;
      dec.imm = imm5Ext;
      dec.pcInc = ifId.pcInc;
      case (opcode)
        cpuIsaPkg::ADDI: begin
          dec.wrEn = 1'b1;
          decUsesA = 1'b1;
        end
        cpuIsaPkg::LD: begin
          dec.wrEn = 1'b1;
          dec.isLoad = 1'b1;
          decUsesA = 1'b1;
        end
        cpuIsaPkg::ST: begin
          dec.isStore = 1'b1;
          decUsesA = 1'b1;
          decUsesB = 1'b1;
        end
        cpuIsaPkg::BEQZ, cpuIsaPkg::BNEZ: begin
          dec.brZero = (opcode == cpuIsaPkg::BEQZ);
          dec.brNonZero = (opcode == cpuIsaPkg::BNEZ);
          dec.imm = imm8Ext;
          decUsesA = 1'b1;
        end
        cpuIsaPkg::RTYPE: begin
          dec.dest = ifId.instr[cpuIsaPkg::rdLsb +: cpuIsaPkg::regIdxW];
          dec.wrEn = 1'b1;
          decUsesA = 1'b1;
          decUsesB = 1'b1;
        end
        cpuIsaPkg::HALT: dec.halt = 1'b1;
        default: dec.op = cpuIsaPkg::NOP;
      endcase
    end
  end

  // bubble on load-use, taken branch or halt flush
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idEx <= cpuPipePkg::idExBubble;
    end else if (stall || branchTaken || exMem.halt) begin
      idEx <= cpuPipePkg::idExBubble;
    end else begin
      idEx <= dec;
    end
  end

endmodule

`default_nettype wire

/* fetchUnit.sv */
// instruction memory is read combinationally from the PC; a halt freezes the PC until reset
`timescale 1ns/1ns
`default_nettype none

module fetchUnit (
  input  logic              clk,
  input  logic              rstN,
  input  logic              stall,
  input  logic              branchTaken,
  input  cpuIsaPkg::wordT   branchTarget,
  input  cpuPipePkg::exMemT exMem,
  output cpuIsaPkg::wordT   imemAddr,
  input  cpuIsaPkg::wordT   imemData,
  output cpuPipePkg::ifIdT  ifId
);

  cpuIsaPkg::wordT pc;
  cpuIsaPkg::wordT pcInc;
  logic            frozen;
  logic            haltFlush;

  assign pcInc = pc + cpuIsaPkg::pcStep;
  assign imemAddr = pc;

  // halt reaching EX/MEM stops fetch at this very edge
  assign haltFlush = frozen | exMem.halt;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= '0;
      frozen <= 1'b0;
      ifId <= cpuPipePkg::ifIdBubble;
    end else begin
      frozen <= haltFlush;

      if (haltFlush) begin
        pc <= pc;
      end else if (branchTaken) begin
        pc <= branchTarget;
      end else if (!stall) begin
        pc <= pcInc;
      end

      // redirect or halt kills the fetched word
      if (haltFlush || branchTaken) begin
        ifId <= cpuPipePkg::ifIdBubble;
      end else if (!stall) begin
        ifId <= '{instr: imemData, pcInc: pcInc, valid: 1'b1};
      end
    end
  end

endmodule

`default_nettype wire

/* hazardUnit.sv */
// loads are the only producers that stall; everything else is forwarded into execute
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
  input  cpuIsaPkg::regIdxT  rdAddrA,
  input  cpuIsaPkg::regIdxT  rdAddrB,
  input  logic               decUsesA,
  input  logic               decUsesB,
  input  cpuPipePkg::idExT   idEx,
  input  cpuPipePkg::exMemT  exMem,
  input  cpuPipePkg::memWbT  memWb,
  output logic               stall,
  output cpuPipePkg::fwdSelT fwdA,
  output cpuPipePkg::fwdSelT fwdB
);

  // youngest producer wins
  function automatic cpuPipePkg::fwdSelT pickSrc(
    input cpuIsaPkg::regIdxT src,
    input cpuPipePkg::exMemT em,
    input cpuPipePkg::memWbT mw
  );
    if (em.wrEn && em.dest == src) begin
      return cpuPipePkg::FROM_EXMEM;
    end else if (mw.wrEn && mw.dest == src) begin
      return cpuPipePkg::FROM_MEMWB;
    end
    return cpuPipePkg::REGFILE;
  endfunction

  // load in EX whose result decode needs next cycle
  assign stall = idEx.isLoad && idEx.wrEn &&
                 ((decUsesA && idEx.dest == rdAddrA) ||
                  (decUsesB && idEx.dest == rdAddrB));

  assign fwdA = pickSrc(idEx.rs, exMem, memWb);
  assign fwdB = pickSrc(idEx.rt, exMem, memWb);

endmodule

`default_nettype wire

/* regFile.sv */
// writes land at the clock edge; a same-cycle read of the written index sees the new value
`timescale 1ns/1ns
`default_nettype none

module regFile (
  input  logic              clk,
  input  logic              rstN,
  input  cpuIsaPkg::regIdxT rdAddrA,
  input  cpuIsaPkg::regIdxT rdAddrB,
  output cpuIsaPkg::wordT   rdDataA,
  output cpuIsaPkg::wordT   rdDataB,
  input  logic              wbEn,
  input  cpuIsaPkg::regIdxT wbIdx,
  input  cpuIsaPkg::wordT   wbData
);

  cpuIsaPkg::wordT regs [cpuIsaPkg::numRegs];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < cpuIsaPkg::numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEn) begin
      regs[wbIdx] <= wbData;
    end
  end

  // write-before-read bypass
  assign rdDataA = (wbEn && wbIdx == rdAddrA) ? wbData : regs[rdAddrA];
  assign rdDataB = (wbEn && wbIdx == rdAddrB) ? wbData : regs[rdAddrB];

endmodule

`default_nettype wire

/* cpuPipePkg.sv */
// pipeline register layouts; a bubble is a record with every control bit cleared
`default_nettype none

package cpuPipePkg;

  typedef struct packed {
    cpuIsaPkg::wordT instr;
    cpuIsaPkg::wordT pcInc;
    logic            valid;
  } ifIdT;

  typedef struct packed {
    cpuIsaPkg::opcodeT  op;
    cpuIsaPkg::aluFuncT func;
    cpuIsaPkg::regIdxT  rs;
    cpuIsaPkg::regIdxT  rt;
    cpuIsaPkg::regIdxT  dest;
    logic               wrEn;
    logic               isLoad;
    logic               isStore;
    logic               brZero;
    logic               brNonZero;
    logic               halt;
    cpuIsaPkg::wordT    valA;
    cpuIsaPkg::wordT    valB;
    cpuIsaPkg::wordT    imm;
    cpuIsaPkg::wordT    pcInc;
  } idExT;

  typedef struct packed {
    cpuIsaPkg::wordT   aluRes;
    cpuIsaPkg::wordT   stData;
    cpuIsaPkg::regIdxT dest;
    logic              wrEn;
    logic              isLoad;
    logic              isStore;
    logic              halt;
  } exMemT;

  typedef struct packed {
    cpuIsaPkg::wordT   aluRes;
    cpuIsaPkg::wordT   ldData;
    cpuIsaPkg::regIdxT dest;
    logic              wrEn;
    logic              isLoad;
    logic              halt;
  } memWbT;

  // operand source for execute
  typedef enum logic [1:0] {
    REGFILE    = 2'd0,
    FROM_EXMEM = 2'd1,
    FROM_MEMWB = 2'd2
  } fwdSelT;

  localparam ifIdT ifIdBubble = '{instr: cpuIsaPkg::nopWord, pcInc: '0, valid: 1'b0};

  localparam idExT idExBubble = '{
    op: cpuIsaPkg::NOP, func: cpuIsaPkg::ADD,
    rs: '0, rt: '0, dest: '0,
    wrEn: 1'b0, isLoad: 1'b0, isStore: 1'b0,
    brZero: 1'b0, brNonZero: 1'b0, halt: 1'b0,
    valA: '0, valB: '0, imm: '0, pcInc: '0
  };

endpackage

`default_nettype wire

/* cpuIsaPkg.sv */
// ISA subset only (HALT NOP ADDI ADD SUB XOR AND LD ST BEQZ BNEZ); opcodes outside it decode as NOP
`default_nettype none

package cpuIsaPkg;

  // datapath and field widths
  localparam int wordW = 16;
  localparam int regIdxW = 3;
  localparam int opcodeW = 5;
  localparam int funcW = 2;
  localparam int imm5W = 5;
  localparam int imm8W = 8;

  localparam int numRegs = 8;

  typedef logic [wordW-1:0] wordT;
  typedef logic [regIdxW-1:0] regIdxT;

  // lsb of each instruction field
  localparam int opLsb = 11;
  localparam int rsLsb = 8;
  // also the destination of ADDI and LD
  localparam int rtLsb = 5;
  // RTYPE destination
  localparam int rdLsb = 2;
  localparam int funcLsb = 0;
  localparam int imm5Lsb = 0;
  localparam int imm8Lsb = 0;

  typedef enum logic [opcodeW-1:0] {
    HALT  = 5'b00000,
    NOP   = 5'b00001,
    ADDI  = 5'b01000,
    BEQZ  = 5'b01100,
    BNEZ  = 5'b01101,
    ST    = 5'b10000,
    LD    = 5'b10001,
    RTYPE = 5'b11011
  } opcodeT;

  // RTYPE function field where SUB is rs minus rt
  typedef enum logic [funcW-1:0] {
    ADD = 2'b00,
    SUB = 2'b01,
    XOR = 2'b10,
    AND = 2'b11
  } aluFuncT;

  // NOP opcode with every other field zero
  localparam wordT nopWord = 16'h0800;

  // instructions are two bytes apart
  localparam wordT pcStep = 16'd2;

endpackage

`default_nettype wire
